/* Bender.yml */
package:
  name: npc_mem

export_include_dirs:
  - .

sources:
  - files:
      - npc_pkg.sv
      - npc_fetch.sv
      - npc_lsu.sv
      - npc_axi_arbiter.sv
      - npc_sram.sv
      - npc_mem_top.sv
  - target: test
    files:
      - npc_assert.sv
      - tb_npc.sv

/* filelist.f */
+incdir+.
npc_pkg.sv
npc_fetch.sv
npc_lsu.sv
npc_axi_arbiter.sv
npc_sram.sv
npc_mem_top.sv
npc_assert.sv
tb_npc.sv

/* npc_assert.sv */
module npc_assert #(
	parameter int PAY_W = 1
) (
	input logic             clk,
	input logic             rst_n,
	input logic             valid,
	input logic             ready,
	input logic [PAY_W-1:0] payload,
	input logic             grant_a,
	input logic             grant_b,
	input logic             beat_valid,
	input logic             beat_allowed
);

	timeunit 1ns;
	timeprecision 100ps;

	// failures seen so far
	int unsigned fail_cnt = 0;

	// ****************************************
	// handshake and grant rules
	// ****************************************
	// valid and payload held until ready
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		valid && !ready |=> valid && $stable(payload))
		else begin
			fail_cnt++;
			$error("valid dropped or payload changed before ready");
		end

	// never both sides at once
	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(grant_a && grant_b))
		else begin
			fail_cnt++;
			$error("both sides granted in one cycle");
		end

	// read beat only inside a held grant
	a_beat: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid |-> beat_allowed)
		else begin
			fail_cnt++;
			$error("read beat valid without a grant");
		end

endmodule

// arbiter side, fetch ar stalls behind the lsu grant
// at most one unit waits on a read beat
bind npc_axi_arbiter npc_assert #(
	.PAY_W($bits(npc_pkg::ar_t))
) arb_chk (
	.clk(clk),
	.rst_n(rst_n),
	.valid(f_ar_valid),
	.ready(f_ar_ready),
	.payload(f_ar),
	.grant_a(f_r_ready),
	.grant_b(l_r_ready),
	.beat_valid(m_r_valid),
	.beat_allowed(state != npc_pkg::arb_idle)
);

// load/store response under back-pressure
// read beat and write response never arrive together
bind npc_lsu npc_assert #(
	.PAY_W($bits(npc_pkg::lsu_rsp_t))
) lsu_chk (
	.clk(clk),
	.rst_n(rst_n),
	.valid(rsp_valid),
	.ready(rsp_ready),
	.payload(rsp),
	.grant_a(r_valid),
	.grant_b(b_valid),
	.beat_valid(r_valid),
	.beat_allowed(r_ready)
);

/* npc_axi_arbiter.sv */
module npc_axi_arbiter import npc_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  ar_t  f_ar,
	input  logic f_ar_valid,
	output logic f_ar_ready,
	output r_t   f_r,
	output logic f_r_valid,
	input  logic f_r_ready,
	input  ar_t  l_ar,
	input  logic l_ar_valid,
	output logic l_ar_ready,
	output r_t   l_r,
	output logic l_r_valid,
	input  logic l_r_ready,
	output ar_t  m_ar,
	output logic m_ar_valid,
	input  logic m_ar_ready,
	input  r_t   m_r,
	input  logic m_r_valid,
	output logic m_r_ready
);

	arb_state_e state;
	// requester picked this cycle, or the one holding the grant
	arb_state_e sel;

	// load/store wins a tie
	always_comb begin
		case (state)
			arb_idle: begin
				if (l_ar_valid)
					sel = arb_lsu;
				else if (f_ar_valid)
					sel = arb_fetch;
				else
					sel = arb_idle;
			end
			default: sel = state;
		endcase
	end

	// ****************************************
	// grant lock
	// ****************************************
	// held from ar handshake until the read beat is taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= arb_idle;
		end else begin
			case (state)
				arb_idle: if (m_ar_valid && m_ar_ready) state <= sel;
				arb_fetch,
				arb_lsu: if (m_r_valid && m_r_ready) state <= arb_idle;
				default: state <= arb_idle;
			endcase
		end
	end

	// address goes out in the same cycle, no extra stage
	assign m_ar = (sel == arb_lsu) ? l_ar : f_ar;
	assign m_ar_valid = (state == arb_idle) && (l_ar_valid || f_ar_valid);
	assign l_ar_ready = (state == arb_idle) && (sel == arb_lsu) && m_ar_ready;
	assign f_ar_ready = (state == arb_idle) && (sel == arb_fetch) && m_ar_ready;

	// payload to both, valid only to the owner
	assign f_r = m_r;
	assign l_r = m_r;
	assign f_r_valid = (state == arb_fetch) && m_r_valid;
	assign l_r_valid = (state == arb_lsu) && m_r_valid;
	assign m_r_ready = ((state == arb_fetch) && f_r_ready) ||
		((state == arb_lsu) && l_r_ready);

endmodule

/* npc_defines.svh */
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

// ****************************************
// bus geometry
// ****************************************

// byte address width on every channel
`define NPC_ADDR_W 32

// sram depth, counted in 64-bit words
`define NPC_MEM_DWORDS 1024

// ****************************************
// response codes
// ****************************************

// normal completion
`define NPC_RESP_OKAY 2'b00
// address outside the array or bad size
`define NPC_RESP_SLVERR 2'b10

`endif

/* npc_fetch.sv */
`include "npc_defines.svh"

module npc_fetch import npc_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  fetch_req_t req,
	input  logic       req_valid,
	output logic       req_ready,
	output fetch_rsp_t rsp,
	output logic       rsp_valid,
	input  logic       rsp_ready,
	output ar_t        ar,
	output logic       ar_valid,
	input  logic       ar_ready,
	input  r_t         r,
	input  logic       r_valid,
	output logic       r_ready
);

	typedef enum logic [1:0] {
		f_idle,
		f_addr,
		f_wait
	} fetch_state_e;

	fetch_state_e state;
	addr_t pc_q;
	logic r_done;

	assign r_done = (state == f_wait) && r_valid;

	// ****************************************
	// controller
	// ****************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= f_idle;
			rsp_valid <= 1'b0;
		end else begin
			case (state)
				f_idle: if (req_valid && req_ready) state <= f_addr;
				f_addr: if (ar_ready) state <= f_wait;
				f_wait: if (r_valid) state <= f_idle;
				default: state <= f_idle;
			endcase
			// response sits until taken
			if (r_done)
				rsp_valid <= 1'b1;
			else if (rsp_ready)
				rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			pc_q <= req.pc;
		// pick the instruction half by pc bit 2
		if (r_done) begin
			rsp.pc <= pc_q;
			rsp.inst <= pc_q[2] ? r.data[63:32] : r.data[31:0];
			rsp.err <= (r.resp != `NPC_RESP_OKAY);
		end
	end

	// one fetch in flight, next pc only after the response leaves
	assign req_ready = (state == f_idle) && !rsp_valid;

	// whole double word that holds the pc
	assign ar.addr = {pc_q[`NPC_ADDR_W-1:3], 3'b000};
	assign ar.size = size_d;
	assign ar_valid = (state == f_addr);
	assign r_ready = (state == f_wait);

endmodule

/* npc_lsu.sv */
`include "npc_defines.svh"

module npc_lsu import npc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output lsu_rsp_t rsp,
	output logic     rsp_valid,
	input  logic     rsp_ready,
	output ar_t      ar,
	output logic     ar_valid,
	input  logic     ar_ready,
	input  r_t       r,
	input  logic     r_valid,
	output logic     r_ready,
	output aw_t      aw,
	output w_t       w,
	output logic     aw_valid,
	input  logic     aw_ready,
	output logic     w_valid,
	input  logic     w_ready,
	input  resp_t    b_resp,
	input  logic     b_valid,
	output logic     b_ready
);

	typedef enum logic [2:0] {
		l_idle,
		l_rd_addr,
		l_rd_wait,
		l_wr,
		l_wr_resp
	} lsu_state_e;

	// byte offset inside the double word, low bits dropped by size
	function automatic logic [2:0] lane_off(addr_t a, size_e s);
		case (s)
			size_b: lane_off = a[2:0];
			size_h: lane_off = {a[2:1], 1'b0};
			size_w: lane_off = {a[2], 2'b00};
			default: lane_off = 3'b000;
		endcase
	endfunction

	function automatic strb_t lane_strb(logic [2:0] off, size_e s);
		strb_t base;
		case (s)
			size_b: base = 8'h01;
			size_h: base = 8'h03;
			size_w: base = 8'h0f;
			default: base = 8'hff;
		endcase
		lane_strb = base << off;
	endfunction

	// shift the lane down, then sign or zero fill
	function automatic dword_t load_ext(dword_t data, logic [2:0] off, size_e s, logic sgn);
		dword_t lane;
		lane = data >> {off, 3'b000};
		case (s)
			size_b: load_ext = {{56{sgn & lane[7]}}, lane[7:0]};
			size_h: load_ext = {{48{sgn & lane[15]}}, lane[15:0]};
			size_w: load_ext = {{32{sgn & lane[31]}}, lane[31:0]};
			default: load_ext = lane;
		endcase
	endfunction

	lsu_state_e state;
	addr_t addr_q;
	size_e size_q;
	logic sgn_q;
	dword_t wdata_q;
	strb_t strb_q;
	logic aw_done;
	logic w_done;
	logic [2:0] req_off;
	logic rd_done;
	logic wr_done;

	assign req_off = lane_off(req.addr, req.size);
	assign rd_done = (state == l_rd_wait) && r_valid;
	assign wr_done = (state == l_wr_resp) && b_valid;

	// ****************************************
	// controller
	// ****************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= l_idle;
			rsp_valid <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			case (state)
				l_idle: if (req_valid && req_ready) state <= req.store ? l_wr : l_rd_addr;
				l_rd_addr: if (ar_ready) state <= l_rd_wait;
				l_rd_wait: if (r_valid) state <= l_idle;
				l_wr: begin
					// aw and w may finish in different cycles
					if (aw_valid && aw_ready) aw_done <= 1'b1;
					if (w_valid && w_ready) w_done <= 1'b1;
					if ((aw_done || aw_ready) && (w_done || w_ready)) begin
						state <= l_wr_resp;
						aw_done <= 1'b0;
						w_done <= 1'b0;
					end
				end
				l_wr_resp: if (b_valid) state <= l_idle;
				default: state <= l_idle;
			endcase
			if (rd_done || wr_done)
				rsp_valid <= 1'b1;
			else if (rsp_ready)
				rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			addr_q <= {req.addr[`NPC_ADDR_W-1:3], req_off};
			size_q <= req.size;
			sgn_q <= req.signed_ld;
			wdata_q <= req.wdata << {req_off, 3'b000};
			strb_q <= lane_strb(req_off, req.size);
		end
		// stores answer with zero data
		if (rd_done) begin
			rsp.rdata <= load_ext(r.data, addr_q[2:0], size_q, sgn_q);
			rsp.err <= (r.resp != `NPC_RESP_OKAY);
		end else if (wr_done) begin
			rsp.rdata <= '0;
			rsp.err <= (b_resp != `NPC_RESP_OKAY);
		end
	end

	assign req_ready = (state == l_idle) && !rsp_valid;

	// read side, through the arbiter
	assign ar.addr = addr_q;
	assign ar.size = size_q;
	assign ar_valid = (state == l_rd_addr);
	assign r_ready = (state == l_rd_wait);

	// write side, straight to the sram
	assign aw.addr = addr_q;
	assign aw.size = size_q;
	assign w.data = wdata_q;
	assign w.strb = strb_q;
	assign aw_valid = (state == l_wr) && !aw_done;
	assign w_valid = (state == l_wr) && !w_done;
	assign b_ready = (state == l_wr_resp);

endmodule

/* npc_mem_top.sv */
module npc_mem_top import npc_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  fetch_req_t fetch_req,
	input  logic       fetch_req_valid,
	output logic       fetch_req_ready,
	output fetch_rsp_t fetch_rsp,
	output logic       fetch_rsp_valid,
	input  logic       fetch_rsp_ready,
	input  lsu_req_t   lsu_req,
	input  logic       lsu_req_valid,
	output logic       lsu_req_ready,
	output lsu_rsp_t   lsu_rsp,
	output logic       lsu_rsp_valid,
	input  logic       lsu_rsp_ready
);

	// ****************************************
	// read channels, units to arbiter to sram
	// ****************************************
	ar_t f_ar;
	logic f_ar_valid;
	logic f_ar_ready;
	r_t f_r;
	logic f_r_valid;
	logic f_r_ready;
	ar_t l_ar;
	logic l_ar_valid;
	logic l_ar_ready;
	r_t l_r;
	logic l_r_valid;
	logic l_r_ready;
	ar_t m_ar;
	logic m_ar_valid;
	logic m_ar_ready;
	r_t m_r;
	logic m_r_valid;
	logic m_r_ready;

	// write channels, load/store only
	aw_t aw;
	logic aw_valid;
	logic aw_ready;
	w_t w;
	logic w_valid;
	logic w_ready;
	resp_t b_resp;
	logic b_valid;
	logic b_ready;

	npc_fetch ifu (
		.clk(clk), .rst_n(rst_n),
		.req(fetch_req), .req_valid(fetch_req_valid), .req_ready(fetch_req_ready),
		.rsp(fetch_rsp), .rsp_valid(fetch_rsp_valid), .rsp_ready(fetch_rsp_ready),
		.ar(f_ar), .ar_valid(f_ar_valid), .ar_ready(f_ar_ready),
		.r(f_r), .r_valid(f_r_valid), .r_ready(f_r_ready)
	);

	npc_lsu lsu (
		.clk(clk), .rst_n(rst_n),
		.req(lsu_req), .req_valid(lsu_req_valid), .req_ready(lsu_req_ready),
		.rsp(lsu_rsp), .rsp_valid(lsu_rsp_valid), .rsp_ready(lsu_rsp_ready),
		.ar(l_ar), .ar_valid(l_ar_valid), .ar_ready(l_ar_ready),
		.r(l_r), .r_valid(l_r_valid), .r_ready(l_r_ready),
		.aw(aw), .w(w), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w_valid(w_valid), .w_ready(w_ready),
		.b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready)
	);

	npc_axi_arbiter arbiter0 (
		.clk(clk), .rst_n(rst_n),
		.f_ar(f_ar), .f_ar_valid(f_ar_valid), .f_ar_ready(f_ar_ready),
		.f_r(f_r), .f_r_valid(f_r_valid), .f_r_ready(f_r_ready),
		.l_ar(l_ar), .l_ar_valid(l_ar_valid), .l_ar_ready(l_ar_ready),
		.l_r(l_r), .l_r_valid(l_r_valid), .l_r_ready(l_r_ready),
		.m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready)
	);

	npc_sram sram_mem (
		.clk(clk), .rst_n(rst_n),
		.ar(m_ar), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
		.r(m_r), .r_valid(m_r_valid), .r_ready(m_r_ready),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready)
	);

endmodule

/* npc_pkg.sv */
`include "npc_defines.svh"

package npc_pkg;

	// ****************************************
	// widths with a meaning
	// ****************************************
	typedef logic [`NPC_ADDR_W-1:0] addr_t;
	typedef logic [63:0] dword_t;
	typedef logic [31:0] inst_t;
	typedef logic [7:0] strb_t;
	typedef logic [1:0] resp_t;

	// same codes as the axi size field
	typedef enum logic [2:0] {
		size_b = 3'd0,
		size_h = 3'd1,
		size_w = 3'd2,
		size_d = 3'd3
	} size_e;

	// owner of the shared read channel
	typedef enum logic [1:0] {
		arb_idle,
		arb_fetch,
		arb_lsu
	} arb_state_e;

	// ****************************************
	// bus channels, single beat only
	// ****************************************
	typedef struct packed {
		addr_t addr;
		size_e size;
	} ar_t;

	typedef struct packed {
		dword_t data;
		resp_t resp;
	} r_t;

	typedef struct packed {
		addr_t addr;
		size_e size;
	} aw_t;

	typedef struct packed {
		dword_t data;
		strb_t strb;
	} w_t;

	// ****************************************
	// unit request and response
	// ****************************************
	typedef struct packed {
		addr_t pc;
	} fetch_req_t;

	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic err;
	} fetch_rsp_t;

	// store data sits in the low bytes, as in a register
	typedef struct packed {
		addr_t addr;
		dword_t wdata;
		size_e size;
		logic store;
		logic signed_ld;
	} lsu_req_t;

	typedef struct packed {
		dword_t rdata;
		logic err;
	} lsu_rsp_t;

endpackage

/* npc_sram.sv */
`include "npc_defines.svh"

module npc_sram import npc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  ar_t   ar,
	input  logic  ar_valid,
	output logic  ar_ready,
	output r_t    r,
	output logic  r_valid,
	input  logic  r_ready,
	input  aw_t   aw,
	input  logic  aw_valid,
	output logic  aw_ready,
	input  w_t    w,
	input  logic  w_valid,
	output logic  w_ready,
	output resp_t b_resp,
	output logic  b_valid,
	input  logic  b_ready
);

	localparam int IDX_W = $clog2(`NPC_MEM_DWORDS);

	dword_t mem [`NPC_MEM_DWORDS];

	logic [IDX_W-1:0] ridx;
	logic [IDX_W-1:0] widx;
	logic rd_ok;
	logic wr_ok;
	logic ar_fire;
	logic wr_fire;

	// word index from the bits above the byte offset
	assign ridx = ar.addr[IDX_W+2:3];
	assign widx = aw.addr[IDX_W+2:3];

	// inside the array, and no beat wider than the bus
	assign rd_ok = (ar.addr[`NPC_ADDR_W-1:3] < `NPC_MEM_DWORDS) && (ar.size <= size_d);
	assign wr_ok = (aw.addr[`NPC_ADDR_W-1:3] < `NPC_MEM_DWORDS) && (aw.size <= size_d);

	// ****************************************
	// read channel
	// ****************************************
	// one beat pending at most
	assign ar_ready = !r_valid;
	assign ar_fire = ar_valid && ar_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			r_valid <= 1'b0;
		else if (ar_fire)
			r_valid <= 1'b1;
		else if (r_ready)
			r_valid <= 1'b0;
	end

	// zero data on error
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			r.data <= rd_ok ? mem[ridx] : '0;
			r.resp <= rd_ok ? `NPC_RESP_OKAY : `NPC_RESP_SLVERR;
		end
	end

	// ****************************************
	// write channel
	// ****************************************
	// aw and w accepted together, never one alone
	assign wr_fire = aw_valid && w_valid && !b_valid;
	assign aw_ready = wr_fire;
	assign w_ready = wr_fire;

	always_ff @(posedge clk) begin
		if (!rst_n)
			b_valid <= 1'b0;
		else if (wr_fire)
			b_valid <= 1'b1;
		else if (b_ready)
			b_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_fire)
			b_resp <= wr_ok ? `NPC_RESP_OKAY : `NPC_RESP_SLVERR;
		// out of range writes are dropped
		if (wr_fire && wr_ok) begin
			for (int i = 0; i < 8; i++) begin
				if (w.strb[i])
					mem[widx][i*8 +: 8] <= w.data[i*8 +: 8];
			end
		end
	end

endmodule

/* tb_npc.sv */
`include "npc_defines.svh"

module tb_npc import npc_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// ****************************************
	// run length
	// ****************************************
	localparam int MEM_BYTES = `NPC_MEM_DWORDS * 8;
	localparam int N_FILL = 64;
	localparam int N_LOADS = 200;
	localparam int N_NARROW = 100;
	localparam int N_FETCH = 50;
	localparam int N_OOR = 8;
	localparam int N_CONC = 100;
	// narrow pass issues two ops per round, oor pass four
	localparam int N_OPS = N_FILL + N_LOADS + 2 * N_NARROW + N_FETCH + 4 * N_OOR + 2 * N_CONC;
	// 40 cycles of 40 ns per op, plus slack
	localparam int WD_NS = (N_OPS * 40 + 500) * 40;

	logic clk;
	logic rst_n;
	fetch_req_t fetch_req;
	logic fetch_req_valid;
	logic fetch_req_ready;
	fetch_rsp_t fetch_rsp;
	logic fetch_rsp_valid;
	logic fetch_rsp_ready;
	lsu_req_t lsu_req;
	logic lsu_req_valid;
	logic lsu_req_ready;
	lsu_rsp_t lsu_rsp;
	logic lsu_rsp_valid;
	logic lsu_rsp_ready;

	integer seed;
	// byte image of the sram
	logic [7:0] ref_mem [MEM_BYTES];

	npc_mem_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ****************************************
	// reference model
	// ****************************************
	function automatic logic addr_ok(addr_t a);
		return (a >> 3) < `NPC_MEM_DWORDS;
	endfunction

	// low bits inside the size are ignored
	function automatic addr_t access_base(addr_t a, size_e s);
		return a & ~((addr_t'(1) << s) - 1);
	endfunction

	function automatic lsu_rsp_t expect_load(addr_t a, size_e s, logic sgn);
		lsu_rsp_t e;
		addr_t base;
		int n;
		e = '0;
		n = 1 << s;
		// beyond the array, zero data and err
		if (!addr_ok(a)) begin
			e.err = 1'b1;
		end else begin
			base = access_base(a, s);
			for (int i = 0; i < n; i++)
				e.rdata[i*8 +: 8] = ref_mem[base + i];
			// sign fill above the top loaded bit
			if (sgn && n < 8 && e.rdata[n*8-1])
				e.rdata = e.rdata | ({64{1'b1}} << (n * 8));
		end
		return e;
	endfunction

	// word picked by pc bit 2 out of its double word
	function automatic fetch_rsp_t expect_fetch(addr_t pc);
		fetch_rsp_t e;
		addr_t base;
		e.pc = pc;
		e.inst = '0;
		e.err = 1'b0;
		if (!addr_ok(pc)) begin
			e.err = 1'b1;
		end else begin
			base = {pc[`NPC_ADDR_W-1:2], 2'b00};
			for (int i = 0; i < 4; i++)
				e.inst[i*8 +: 8] = ref_mem[base + i];
		end
		return e;
	endfunction

	// store data comes from the low bytes of wdata
	task automatic apply_store(addr_t a, size_e s, dword_t d);
		addr_t base;
		int n;
		n = 1 << s;
		base = access_base(a, s);
		if (addr_ok(a)) begin
			for (int i = 0; i < n; i++)
				ref_mem[base + i] = d[i*8 +: 8];
		end
	endtask

	function automatic addr_t random_addr(addr_t lo, addr_t span);
		return lo + (addr_t'($random(seed)) % span);
	endfunction

	// ****************************************
	// compare tasks
	// ****************************************
	task automatic check_fetch(fetch_rsp_t got, fetch_rsp_t exp);
		if (got !== exp) begin
			$display("ERR @ %0t: fetch pc %h inst %h err %b, expected pc %h inst %h err %b",
				$time, got.pc, got.inst, got.err, exp.pc, exp.inst, exp.err);
			$display("Test FAILED");
			$fatal(1, "fetch response mismatch");
		end
	endtask

	task automatic check_lsu(lsu_rsp_t got, lsu_rsp_t exp);
		if (got !== exp) begin
			$display("ERR @ %0t: lsu rdata %h err %b, expected rdata %h err %b",
				$time, got.rdata, got.err, exp.rdata, exp.err);
			$display("Test FAILED");
			$fatal(1, "lsu response mismatch");
		end
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("ERR @ %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "port level mismatch");
		end
	endtask

	// ****************************************
	// port drivers
	// ****************************************
	// enter and leave 2 ns after a rising edge
	task automatic fetch_op(addr_t pc);
		fetch_rsp_t exp;
		fetch_rsp_t got;
		logic hs;
		fetch_req.pc = pc;
		fetch_req_valid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = fetch_req_ready;
			if (hs)
				exp = expect_fetch(pc);
			@(posedge clk);
			#2;
		end
		fetch_req_valid = 1'b0;
		hs = 1'b0;
		// random back-pressure on the response
		while (!hs) begin
			fetch_rsp_ready = ($random(seed) & 3) != 0;
			@(negedge clk);
			hs = fetch_rsp_valid && fetch_rsp_ready;
			got = fetch_rsp;
			@(posedge clk);
			#2;
		end
		fetch_rsp_ready = 1'b0;
		check_fetch(got, exp);
	endtask

	task automatic lsu_op(addr_t a, size_e s, logic st, logic sgn, dword_t d);
		lsu_rsp_t exp;
		lsu_rsp_t got;
		logic hs;
		lsu_req.addr = a;
		lsu_req.wdata = d;
		lsu_req.size = s;
		lsu_req.store = st;
		lsu_req.signed_ld = sgn;
		lsu_req_valid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = lsu_req_ready;
			// model moves at the request handshake
			if (hs && st) begin
				apply_store(a, s, d);
				exp.rdata = '0;
				exp.err = !addr_ok(a);
			end else if (hs) begin
				exp = expect_load(a, s, sgn);
			end
			@(posedge clk);
			#2;
		end
		lsu_req_valid = 1'b0;
		hs = 1'b0;
		while (!hs) begin
			lsu_rsp_ready = ($random(seed) & 3) != 0;
			@(negedge clk);
			hs = lsu_rsp_valid && lsu_rsp_ready;
			got = lsu_rsp;
			@(posedge clk);
			#2;
		end
		lsu_rsp_ready = 1'b0;
		check_lsu(got, exp);
	endtask

	// any size, signed or not, store only if allowed
	task automatic random_access(addr_t lo, addr_t span, logic allow_st);
		logic [31:0] r;
		r = $random(seed);
		lsu_op(random_addr(lo, span), size_e'(r[3:2]), allow_st & r[0], r[1],
			{$random(seed), $random(seed)});
	endtask

	// ****************************************
	// test sequence
	// ****************************************
	initial begin
		addr_t a;
		addr_t oor;
		logic [31:0] r;
		seed = 6;
		fetch_req = '0;
		fetch_req_valid = 1'b0;
		fetch_rsp_ready = 1'b0;
		lsu_req = '0;
		lsu_req_valid = 1'b0;
		lsu_rsp_ready = 1'b0;
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// idle levels right after reset
		repeat (3) begin
			@(negedge clk);
			check_flag("fetch_rsp_valid", fetch_rsp_valid, 1'b0);
			check_flag("lsu_rsp_valid", lsu_rsp_valid, 1'b0);
			check_flag("fetch_req_ready", fetch_req_ready, 1'b1);
			check_flag("lsu_req_ready", lsu_req_ready, 1'b1);
		end
		@(posedge clk);
		#2;
		// fill the low region, then loads of every kind
		for (int i = 0; i < N_FILL; i++)
			lsu_op(addr_t'(i * 8), size_d, 1'b1, 1'b0, {$random(seed), $random(seed)});
		repeat (N_LOADS) random_access(0, N_FILL * 8, 1'b0);
		// narrow stores, whole dword read back
		repeat (N_NARROW) begin
			r = $random(seed);
			a = random_addr(0, N_FILL * 8);
			lsu_op(a, size_e'(r[1:0] % 3), 1'b1, 1'b0, {$random(seed), $random(seed)});
			lsu_op(a, size_d, 1'b0, 1'b0, '0);
		end
		repeat (N_FETCH) fetch_op(random_addr(0, N_FILL * 8) & ~32'h3);
		// beyond the array, same low bits as a live dword
		repeat (N_OOR) begin
			r = $random(seed);
			a = random_addr(0, N_FILL * 8);
			oor = a | 32'h2000 | (addr_t'($random(seed)) & 32'hffff_c000);
			lsu_op(oor & ~32'h7, size_d, 1'b1, 1'b0, {$random(seed), $random(seed)});
			lsu_op(a & ~32'h7, size_d, 1'b0, 1'b0, '0);
			lsu_op(oor, size_e'(r[1:0]), 1'b0, r[2], '0);
			fetch_op(oor & ~32'h3);
		end
		// both ports at once, disjoint regions
		fork
			repeat (N_CONC) fetch_op(random_addr(0, 256) & ~32'h3);
			repeat (N_CONC) random_access(256, 256, 1'b1);
		join
		if (UUT.arbiter0.arb_chk.fail_cnt + UUT.lsu.lsu_chk.fail_cnt != 0) begin
			$display("bound assertions reported failures during the run");
			$display("Test FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	// watchdog
	initial begin
		#(WD_NS);
		$display("timeout: run did not finish within %0d ns", WD_NS);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
